//--- rtl/hci_params.svh
// Copy engine parameters
// Memory channel widths, bank geometry and the host register map
`ifndef HCI_PARAMS_SVH
`define HCI_PARAMS_SVH

// Memory channels, word addressed
`define HCI_AW      8
`define HCI_DW      32
`define BANK_DEPTH  256
`define NB_IN_CHAN  3

// Host bus, byte addressed
`define AXI_AW      12
`define LEN_W       9

`define REG_SRC     12'h000
`define REG_DST     12'h004
`define REG_LEN     12'h008
`define REG_CTRL    12'h00C
`define REG_STATUS  12'h010
`define MEM_BASE    12'h400

`endif

//--- rtl/hci_core_pkg.sv
// Memory channel types
// Channel indices into the multiplexer and the HCI write-enable opcode
package hci_core_pkg;

  // Request channels of the memory multiplexer
  typedef enum logic [1:0] {
    CH_LOAD  = 2'd0,
    CH_STORE = 2'd1,
    CH_HOST  = 2'd2
  } hci_chan_e;

  // HCI convention, wen high means read
  typedef enum logic {
    OP_WRITE = 1'b0,
    OP_READ  = 1'b1
  } hci_op_e;

endpackage

//--- rtl/copy_ctrl_pkg.sv
// Copy engine control types
// Controller states and the host register index
`include "hci_params.svh"

package copy_ctrl_pkg;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_BUSY = 2'd1,
    ST_DONE = 2'd2
  } copy_state_e;

  // Byte offset divided by 4
  typedef enum logic [2:0] {
    IDX_SRC    = 3'(`REG_SRC >> 2),
    IDX_DST    = 3'(`REG_DST >> 2),
    IDX_LEN    = 3'(`REG_LEN >> 2),
    IDX_CTRL   = 3'(`REG_CTRL >> 2),
    IDX_STATUS = 3'(`REG_STATUS >> 2)
  } copy_reg_e;

endpackage

//--- rtl/copy_regs.sv
// Copy engine host port
// AXI4-Lite target for the control registers and the scratchpad window
`timescale 1ns/1ps
`include "hci_params.svh"

module copy_regs (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [`AXI_AW-1:0]    awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [`HCI_DW-1:0]    wdata,
  input  logic [`HCI_DW/8-1:0]  wstrb,
  input  logic                  wvalid,
  output logic                  wready,
  output logic [1:0]            bresp,
  output logic                  bvalid,
  input  logic                  bready,
  input  logic [`AXI_AW-1:0]    araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [`HCI_DW-1:0]    rdata,
  output logic [1:0]            rresp,
  output logic                  rvalid,
  input  logic                  rready,
  output logic [`HCI_AW-1:0]    src_addr,
  output logic [`HCI_AW-1:0]    dst_addr,
  output logic [`LEN_W-1:0]     len,
  output logic                  start,
  input  logic                  busy,
  input  logic                  done,
  output logic                  host_req,
  output logic                  host_wen,
  output logic [`HCI_AW-1:0]    host_add,
  output logic [`HCI_DW-1:0]    host_data,
  input  logic                  host_gnt,
  input  logic                  host_r_valid,
  input  logic [`HCI_DW-1:0]    host_r_data
);
  import hci_core_pkg::*;
  import copy_ctrl_pkg::*;

  logic [`AXI_AW-1:0] aw_addr_q, wr_addr;
  logic [`HCI_DW-1:0] w_data_q, wr_data, reg_rdata;
  logic               w_en_q, wr_en;
  logic               aw_got, w_got, rd_wait, done_q, idle;
  logic               aw_hs, w_hs, ar_hs, wr_fire, host_hs;
  logic               wr_win, wr_reg, rd_win, rd_reg;
  copy_reg_e          wr_idx, rd_idx;

  function automatic logic in_window(logic [`AXI_AW-1:0] addr);
    return (addr >= `MEM_BASE) && (addr < `MEM_BASE + 4 * `BANK_DEPTH);
  endfunction

  // One transaction in flight, writes take priority over reads
  assign idle    = !host_req && !rd_wait && !bvalid && !rvalid;
  assign awready = idle && !aw_got;
  assign wready  = idle && !w_got;
  assign arready = idle && !aw_got && !w_got && !awvalid && !wvalid;
  assign aw_hs   = awvalid && awready;
  assign w_hs    = wvalid && wready;
  assign ar_hs   = arvalid && arready;
  assign host_hs = host_req && host_gnt;

  // Write fires once both address and data are held
  assign wr_fire = (aw_got || aw_hs) && (w_got || w_hs);
  assign wr_addr = aw_got ? aw_addr_q : awaddr;
  assign wr_data = w_got ? w_data_q : wdata;
  assign wr_en   = w_got ? w_en_q : |wstrb;

  // Register space is the first 32 bytes
  assign wr_win = in_window(wr_addr);
  assign wr_reg = wr_addr[`AXI_AW-1:5] == '0;
  assign rd_win = in_window(araddr);
  assign rd_reg = araddr[`AXI_AW-1:5] == '0;
  assign wr_idx = copy_reg_e'(wr_addr[4:2]);
  assign rd_idx = copy_reg_e'(araddr[4:2]);

  assign bresp = 2'b00;
  assign rresp = 2'b00;

  always_comb begin
    reg_rdata = '0;
    if (rd_reg) begin
      case (rd_idx)
        IDX_SRC:    reg_rdata = `HCI_DW'(src_addr);
        IDX_DST:    reg_rdata = `HCI_DW'(dst_addr);
        IDX_LEN:    reg_rdata = `HCI_DW'(len);
        IDX_STATUS: reg_rdata = `HCI_DW'({done_q, busy});
        default:    reg_rdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aw_got   <= 1'b0;
      w_got    <= 1'b0;
      host_req <= 1'b0;
      rd_wait  <= 1'b0;
      bvalid   <= 1'b0;
      rvalid   <= 1'b0;
      start    <= 1'b0;
      done_q   <= 1'b0;
      src_addr <= '0;
      dst_addr <= '0;
      len      <= '0;
    end else begin
      aw_got <= !wr_fire && (aw_got || aw_hs);
      w_got  <= !wr_fire && (w_got || w_hs);
      start  <= 1'b0;

      // Sticky done, cleared by the next start
      if (start) begin
        done_q <= 1'b0;
      end else if (done) begin
        done_q <= 1'b1;
      end

      if (wr_fire && wr_en && wr_reg) begin
        case (wr_idx)
          IDX_SRC:  src_addr <= wr_data[`HCI_AW-1:0];
          IDX_DST:  dst_addr <= wr_data[`HCI_AW-1:0];
          IDX_LEN:  len      <= wr_data[`LEN_W-1:0];
          IDX_CTRL: start    <= wr_data[0];
          default:  ;
        endcase
      end

      // Window accesses become HCI requests held until gnt
      if (host_hs) begin
        host_req <= 1'b0;
      end else if ((wr_fire && wr_win && wr_en) || (ar_hs && rd_win)) begin
        host_req <= 1'b1;
      end

      if (host_hs && host_wen == OP_READ) begin
        rd_wait <= 1'b1;
      end else if (host_r_valid) begin
        rd_wait <= 1'b0;
      end

      if ((wr_fire && !(wr_win && wr_en)) || (host_hs && host_wen == OP_WRITE)) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end

      if ((ar_hs && !rd_win) || (rd_wait && host_r_valid)) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      aw_addr_q <= awaddr;
    end
    if (w_hs) begin
      w_data_q <= wdata;
      w_en_q   <= |wstrb;
    end
    if (wr_fire) begin
      host_wen  <= OP_WRITE;
      host_add  <= wr_addr[`HCI_AW+1:2];
      host_data <= wr_data;
    end else if (ar_hs) begin
      host_wen <= OP_READ;
      host_add <= araddr[`HCI_AW+1:2];
    end
    if (ar_hs && !rd_win) begin
      rdata <= reg_rdata;
    end else if (rd_wait && host_r_valid) begin
      rdata <= host_r_data;
    end
  end

endmodule

//--- rtl/copy_fsm.sv
// Copy controller
// Sequences a copy from start until the last store is granted
`timescale 1ns/1ps

module copy_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start,
  input  logic wr_zero,
  output logic load_cnt,
  output logic busy,
  output logic done,
  input  logic len_zero
);
  import copy_ctrl_pkg::*;

  copy_state_e state_q, state_d;

  // Start is only taken when idle
  assign load_cnt = start && (state_q == ST_IDLE);
  assign busy     = state_q == ST_BUSY;
  assign done     = state_q == ST_DONE;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (start) begin
          state_d = len_zero ? ST_DONE : ST_BUSY;
        end
      end
      ST_BUSY: begin
        if (wr_zero) begin
          state_d = ST_DONE;
        end
      end
      // Done lasts a single cycle
      ST_DONE: state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

//--- rtl/beat_counter.sv
// Remaining-word counter
// Loads a length, counts granted beats down and flags zero
`timescale 1ns/1ps
`include "hci_params.svh"

module beat_counter (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              load,
  input  logic [`LEN_W-1:0] len,
  input  logic              dec,
  output logic              zero
);

  logic [`LEN_W-1:0] cnt_q;

  assign zero = cnt_q == '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (load) begin
      cnt_q <= len;
    end else if (dec && !zero) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

endmodule

//--- rtl/copy_streamer.sv
// Copy datapath
// Load and store address pointers with a two-entry buffer in between
`timescale 1ns/1ps
`include "hci_params.svh"

module copy_streamer (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               busy,
  input  logic               load_cnt,
  input  logic [`HCI_AW-1:0] src_addr,
  input  logic [`HCI_AW-1:0] dst_addr,
  input  logic               rd_zero,
  output logic               rd_dec,
  output logic               wr_dec,
  output logic               ld_req,
  output logic [`HCI_AW-1:0] ld_add,
  output logic               ld_wen,
  input  logic               ld_gnt,
  input  logic               ld_r_valid,
  input  logic [`HCI_DW-1:0] ld_r_data,
  output logic               st_req,
  output logic [`HCI_AW-1:0] st_add,
  output logic               st_wen,
  output logic [`HCI_DW-1:0] st_data,
  input  logic               st_gnt
);
  import hci_core_pkg::*;

  logic [`HCI_DW-1:0] buf_q [2];
  logic               buf_wr_idx;
  logic               buf_rd_idx;
  logic [1:0]         buf_cnt;
  logic [1:0]         in_flight;
  logic               room;

  // Reads in flight reserve their slot, so the buffer never overflows
  assign room    = (buf_cnt + in_flight) < 2'd2;
  assign ld_req  = busy && !rd_zero && room;
  assign st_req  = busy && (buf_cnt != 2'd0);
  assign ld_wen  = OP_READ;
  assign st_wen  = OP_WRITE;
  assign st_data = buf_q[buf_rd_idx];
  assign rd_dec  = ld_req && ld_gnt;
  assign wr_dec  = st_req && st_gnt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ld_add     <= '0;
      st_add     <= '0;
      buf_wr_idx <= 1'b0;
      buf_rd_idx <= 1'b0;
      buf_cnt    <= '0;
      in_flight  <= '0;
    end else begin
      if (load_cnt) begin
        ld_add <= src_addr;
        st_add <= dst_addr;
      end else begin
        if (rd_dec) begin
          ld_add <= ld_add + 1'b1;
        end
        if (wr_dec) begin
          st_add <= st_add + 1'b1;
        end
      end
      if (ld_r_valid) begin
        buf_wr_idx <= !buf_wr_idx;
      end
      if (wr_dec) begin
        buf_rd_idx <= !buf_rd_idx;
      end
      in_flight <= in_flight + {1'b0, rd_dec} - {1'b0, ld_r_valid};
      buf_cnt   <= buf_cnt + {1'b0, ld_r_valid} - {1'b0, wr_dec};
    end
  end

  always_ff @(posedge clk_i) begin
    if (ld_r_valid) begin
      buf_q[buf_wr_idx] <= ld_r_data;
    end
  end

endmodule

//--- rtl/hci_core_mux_dynamic.sv
// HCI round-robin multiplexer
// Funnels the request channels into one memory port by rotating priority
`timescale 1ns/1ps
`include "hci_params.svh"

module hci_core_mux_dynamic (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  clear,
  input  logic [`NB_IN_CHAN-1:0]                in_req,
  input  logic [`NB_IN_CHAN-1:0][`HCI_AW-1:0]   in_add,
  input  logic [`NB_IN_CHAN-1:0]                in_wen,
  input  logic [`NB_IN_CHAN-1:0][`HCI_DW-1:0]   in_data,
  output logic [`NB_IN_CHAN-1:0]                in_gnt,
  output logic [`NB_IN_CHAN-1:0]                in_r_valid,
  output logic [`NB_IN_CHAN-1:0][`HCI_DW-1:0]   in_r_data,
  output logic                                  out_req,
  output logic [`HCI_AW-1:0]                    out_add,
  output logic                                  out_wen,
  output logic [`HCI_DW-1:0]                    out_data,
  input  logic                                  out_gnt,
  input  logic                                  out_r_valid,
  input  logic [`HCI_DW-1:0]                    out_r_data
);
  import hci_core_pkg::*;

  localparam int unsigned CW = $bits(hci_chan_e);

  logic [CW-1:0] rr_counter;
  hci_chan_e     winner_d;
  hci_chan_e     winner_q;
  logic          out_req_q;
  logic          rr_en;

  // Rotate whenever a requester had to wait
  assign rr_en = out_req && out_gnt && |(in_req & ~in_gnt);

  always_ff @(posedge clk_i or negedge rst_ni) begin : rr_count
    if (!rst_ni) begin
      rr_counter <= '0;
    end else if (clear) begin
      rr_counter <= '0;
    end else if (rr_en) begin
      rr_counter <= (rr_counter == CW'(`NB_IN_CHAN - 1)) ? '0 : rr_counter + 1'b1;
    end
  end

  // Slot at the counter has top priority, then the following slots
  always_comb begin : winner_sel
    int slot;
    winner_d = hci_chan_e'(rr_counter);
    for (int k = `NB_IN_CHAN - 1; k >= 0; k--) begin
      slot = (int'(rr_counter) + k) % `NB_IN_CHAN;
      if (in_req[slot]) begin
        winner_d = hci_chan_e'(slot[CW-1:0]);
      end
    end
  end

  assign out_req  = |in_req;
  assign out_add  = in_add[winner_d];
  assign out_wen  = in_wen[winner_d];
  assign out_data = in_data[winner_d];

  // Grant follows the current winner, responses the registered one
  always_comb begin : resp_route
    in_gnt               = '0;
    in_r_valid           = '0;
    in_r_data            = '0;
    in_gnt[winner_d]     = out_gnt & in_req[winner_d];
    in_r_valid[winner_q] = out_r_valid & out_req_q;
    in_r_data[winner_q]  = out_r_data;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : winner_reg
    if (!rst_ni) begin
      winner_q  <= CH_LOAD;
      out_req_q <= 1'b0;
    end else if (clear) begin
      winner_q  <= CH_LOAD;
      out_req_q <= 1'b0;
    end else begin
      winner_q  <= winner_d;
      out_req_q <= out_req;
    end
  end

endmodule

//--- rtl/tcdm_bank.sv
// Scratchpad bank
// Single-port word memory, always granted, reads return one cycle later
`timescale 1ns/1ps
`include "hci_params.svh"

module tcdm_bank (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req,
  input  logic               wen,
  input  logic [`HCI_AW-1:0] add,
  input  logic [`HCI_DW-1:0] data,
  output logic               gnt,
  output logic               r_valid,
  output logic [`HCI_DW-1:0] r_data
);
  import hci_core_pkg::*;

  logic [`HCI_DW-1:0] mem_q [`BANK_DEPTH];

  assign gnt = 1'b1;

  always_ff @(posedge clk_i) begin
    if (req && wen == OP_WRITE) begin
      mem_q[add] <= data;
    end
    if (req && wen == OP_READ) begin
      r_data <= mem_q[add];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= req && (wen == OP_READ);
    end
  end

endmodule

//--- rtl/copy_top.sv
// Memory-copy engine
// Host registers, copy control and datapath sharing one scratchpad bank
`timescale 1ns/1ps
`include "hci_params.svh"

module copy_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [`AXI_AW-1:0]    awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [`HCI_DW-1:0]    wdata,
  input  logic [`HCI_DW/8-1:0]  wstrb,
  input  logic                  wvalid,
  output logic                  wready,
  output logic [1:0]            bresp,
  output logic                  bvalid,
  input  logic                  bready,
  input  logic [`AXI_AW-1:0]    araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [`HCI_DW-1:0]    rdata,
  output logic [1:0]            rresp,
  output logic                  rvalid,
  input  logic                  rready
);
  import hci_core_pkg::*;

  logic [`HCI_AW-1:0] src_addr, dst_addr;
  logic [`LEN_W-1:0]  len;
  logic               start, busy, done, load_cnt, len_zero;
  logic               rd_zero, wr_zero, rd_dec, wr_dec;

  // Per-channel HCI signals
  logic               host_req, host_wen, host_gnt, host_r_valid;
  logic [`HCI_AW-1:0] host_add, ld_add, st_add, mem_add;
  logic [`HCI_DW-1:0] host_data, host_r_data, ld_r_data, st_data;
  logic               ld_req, ld_wen, ld_gnt, ld_r_valid;
  logic               st_req, st_wen, st_gnt;
  logic               mem_req, mem_wen, mem_gnt, mem_r_valid;
  logic [`HCI_DW-1:0] mem_data, mem_r_data;

  // Multiplexer channel vectors
  logic [`NB_IN_CHAN-1:0]              in_req, in_wen, in_gnt, in_r_valid;
  logic [`NB_IN_CHAN-1:0][`HCI_AW-1:0] in_add;
  logic [`NB_IN_CHAN-1:0][`HCI_DW-1:0] in_data, in_r_data;

  assign len_zero = len == '0;

  assign in_req[CH_LOAD]   = ld_req;
  assign in_add[CH_LOAD]   = ld_add;
  assign in_wen[CH_LOAD]   = ld_wen;
  assign in_data[CH_LOAD]  = '0;
  assign in_req[CH_STORE]  = st_req;
  assign in_add[CH_STORE]  = st_add;
  assign in_wen[CH_STORE]  = st_wen;
  assign in_data[CH_STORE] = st_data;
  assign in_req[CH_HOST]   = host_req;
  assign in_add[CH_HOST]   = host_add;
  assign in_wen[CH_HOST]   = host_wen;
  assign in_data[CH_HOST]  = host_data;

  assign ld_gnt       = in_gnt[CH_LOAD];
  assign ld_r_valid   = in_r_valid[CH_LOAD];
  assign ld_r_data    = in_r_data[CH_LOAD];
  assign st_gnt       = in_gnt[CH_STORE];
  assign host_gnt     = in_gnt[CH_HOST];
  assign host_r_valid = in_r_valid[CH_HOST];
  assign host_r_data  = in_r_data[CH_HOST];

  copy_regs u_regs (
    .clk_i, .rst_ni,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready,
    .src_addr, .dst_addr, .len, .start, .busy, .done,
    .host_req, .host_wen, .host_add, .host_data,
    .host_gnt, .host_r_valid, .host_r_data
  );

  copy_fsm u_fsm (
    .clk_i, .rst_ni, .start, .wr_zero, .load_cnt, .busy, .done, .len_zero
  );

  beat_counter u_rd_cnt (
    .clk_i, .rst_ni, .load(load_cnt), .len, .dec(rd_dec), .zero(rd_zero)
  );

  beat_counter u_wr_cnt (
    .clk_i, .rst_ni, .load(load_cnt), .len, .dec(wr_dec), .zero(wr_zero)
  );

  copy_streamer u_streamer (
    .clk_i, .rst_ni, .busy, .load_cnt, .src_addr, .dst_addr,
    .rd_zero, .rd_dec, .wr_dec,
    .ld_req, .ld_add, .ld_wen, .ld_gnt, .ld_r_valid, .ld_r_data,
    .st_req, .st_add, .st_wen, .st_data, .st_gnt
  );

  hci_core_mux_dynamic u_mux (
    .clk_i, .rst_ni, .clear(1'b0),
    .in_req, .in_add, .in_wen, .in_data, .in_gnt, .in_r_valid, .in_r_data,
    .out_req(mem_req), .out_add(mem_add), .out_wen(mem_wen), .out_data(mem_data),
    .out_gnt(mem_gnt), .out_r_valid(mem_r_valid), .out_r_data(mem_r_data)
  );

  tcdm_bank u_bank (
    .clk_i, .rst_ni, .req(mem_req), .wen(mem_wen), .add(mem_add), .data(mem_data),
    .gnt(mem_gnt), .r_valid(mem_r_valid), .r_data(mem_r_data)
  );

endmodule

//--- verif/copy_chk.sv
// Copy engine protocol checker
// Bound assertions on mux grants, channel responses and the host bus
`timescale 1ns/1ps
`include "hci_params.svh"

module copy_chk (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic [`NB_IN_CHAN-1:0] in_req,
  input logic [`NB_IN_CHAN-1:0] in_wen,
  input logic [`NB_IN_CHAN-1:0] in_gnt,
  input logic [`NB_IN_CHAN-1:0] in_r_valid,
  input logic                   mem_req,
  input logic                   mem_gnt,
  input logic                   busy,
  input logic                   done,
  input logic                   rd_zero,
  input logic                   wr_zero,
  input logic                   awvalid,
  input logic                   awready,
  input logic                   wvalid,
  input logic                   wready,
  input logic                   arvalid,
  input logic                   arready,
  input logic                   bvalid,
  input logic                   bready,
  input logic                   rvalid,
  input logic                   rready
);
  import hci_core_pkg::*;

  int unsigned            fail_cnt = 0;
  logic [`NB_IN_CHAN-1:0] rd_gnt;

  // Granted reads per channel
  always_comb begin
    for (int c = 0; c < `NB_IN_CHAN; c++) begin
      rd_gnt[c] = in_gnt[c] && (in_wen[c] == OP_READ);
    end
  end

  // One grant per served cycle and none to an idle channel
  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(in_gnt) && ((in_gnt & ~in_req) == '0) && ((|in_gnt) == (mem_req && mem_gnt)))
    else begin $error("mux grant is not one-hot or does not match the memory port"); fail_cnt++; end

  // Each channel sees r_valid exactly one cycle after its granted read
  a_rd_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_r_valid == $past(rd_gnt))
    else begin $error("channel r_valid does not follow its granted read"); fail_cnt++; end

  a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    awvalid && !awready |=> awvalid)
    else begin $error("awvalid dropped before awready"); fail_cnt++; end
  a_w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wvalid && !wready |=> wvalid)
    else begin $error("wvalid dropped before wready"); fail_cnt++; end
  a_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    arvalid && !arready |=> arvalid)
    else begin $error("arvalid dropped before arready"); fail_cnt++; end
  a_b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bvalid && !bready |=> bvalid)
    else begin $error("bvalid dropped before bready"); fail_cnt++; end
  a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid && !rready |=> rvalid)
    else begin $error("rvalid dropped before rready"); fail_cnt++; end

  // Done only once every load and store has been granted
  a_busy_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done |-> !busy && rd_zero && wr_zero)
    else begin $error("done raised while busy or with words left"); fail_cnt++; end

endmodule

//--- verif/tb_copy.sv
// Memory-copy engine testbench
// Directed AXI4-Lite tests of registers, the scratchpad window and copies
`timescale 1ns/1ps
`include "hci_params.svh"

module tb_copy;
  import copy_ctrl_pkg::*;

  localparam logic [1:0] RESP_OKAY = 2'b00;
  // About 360 host accesses of about ten cycles each plus the copies, with wide margin
  localparam int MAX_CYCLES = 20000;

  logic                 clk_i;
  logic                 rst_ni;
  logic [`AXI_AW-1:0]   awaddr;
  logic [`AXI_AW-1:0]   araddr;
  logic [`HCI_DW-1:0]   wdata;
  logic [`HCI_DW-1:0]   rdata;
  logic [`HCI_DW/8-1:0] wstrb;
  logic [1:0]           bresp;
  logic [1:0]           rresp;
  logic                 awvalid, awready, wvalid, wready, bvalid, bready;
  logic                 arvalid, arready, rvalid, rready;

  logic [`HCI_DW-1:0] shadow [`BANK_DEPTH];
  logic [31:0]        lfsr_q;
  int                 cycles = 0;

  copy_top dut0 (
    .clk_i, .rst_ni,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready
  );

  bind copy_top copy_chk u_chk (
    .clk_i(clk_i), .rst_ni(rst_ni), .in_req(in_req), .in_wen(in_wen), .in_gnt(in_gnt),
    .in_r_valid(in_r_valid), .mem_req(mem_req), .mem_gnt(mem_gnt),
    .busy(busy), .done(done), .rd_zero(rd_zero), .wr_zero(wr_zero),
    .awvalid(awvalid), .awready(awready), .wvalid(wvalid), .wready(wready),
    .arvalid(arvalid), .arready(arready), .bvalid(bvalid), .bready(bready),
    .rvalid(rvalid), .rready(rready)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      abort_run($sformatf("Timeout: run did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [`HCI_DW-1:0] exp,
                            input logic [`HCI_DW-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("** Error [%s] expected %08h actual %08h", name, exp, act));
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("** Error [%s] expected resp %02b actual %02b", name, exp, act));
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_word(output logic [31:0] w);
    w = '0;
    for (int b = 0; b < 32; b++) begin
      lfsr_q = lfsr_step(lfsr_q);
      w = {w[30:0], lfsr_q[0]};
    end
  endtask

  function automatic logic [`AXI_AW-1:0] reg_addr(input copy_reg_e idx);
    return `AXI_AW'({idx, 2'b00});
  endfunction

  function automatic logic [`AXI_AW-1:0] word_addr(input logic [`HCI_AW-1:0] word);
    return `MEM_BASE + `AXI_AW'({word, 2'b00});
  endfunction

  // Ready depends only on DUT state here, so it is stable at the falling edge
  task automatic axi_write(input logic [`AXI_AW-1:0] addr, input logic [`HCI_DW-1:0] data,
                           output logic [1:0] resp);
    logic aw_take;
    logic w_take;
    @(negedge clk_i);
    awaddr  = addr;
    wdata   = data;
    wstrb   = '1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    while (awvalid || wvalid) begin
      aw_take = awvalid && awready;
      w_take  = wvalid && wready;
      @(negedge clk_i);
      if (aw_take) awvalid = 1'b0;
      if (w_take) wvalid = 1'b0;
    end
    while (!bvalid) @(negedge clk_i);
    resp = bresp;
    // Response is held off for one cycle before it is taken
    @(negedge clk_i);
    bready = 1'b1;
    @(negedge clk_i);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [`AXI_AW-1:0] addr, output logic [`HCI_DW-1:0] data,
                          output logic [1:0] resp);
    logic ar_take;
    @(negedge clk_i);
    araddr  = addr;
    arvalid = 1'b1;
    while (arvalid) begin
      ar_take = arready;
      @(negedge clk_i);
      if (ar_take) arvalid = 1'b0;
    end
    while (!rvalid) @(negedge clk_i);
    data = rdata;
    resp = rresp;
    @(negedge clk_i);
    rready = 1'b1;
    @(negedge clk_i);
    rready = 1'b0;
  endtask

  task automatic reg_write(input copy_reg_e idx, input logic [31:0] data, input string name);
    logic [1:0] resp;
    axi_write(reg_addr(idx), data, resp);
    check_resp(name, RESP_OKAY, resp);
  endtask

  task automatic reg_check(input copy_reg_e idx, input logic [31:0] exp, input string name);
    logic [31:0] data;
    logic [1:0]  resp;
    axi_read(reg_addr(idx), data, resp);
    check_resp(name, RESP_OKAY, resp);
    check_word(name, exp, data);
  endtask

  task automatic mem_write(input logic [`HCI_AW-1:0] word, input logic [31:0] data,
                           input string name);
    logic [1:0] resp;
    axi_write(word_addr(word), data, resp);
    check_resp(name, RESP_OKAY, resp);
    shadow[word] = data;
  endtask

  task automatic mem_fill(input int first, input int count, input string name);
    logic [31:0] w;
    for (int i = 0; i < count; i++) begin
      rand_word(w);
      mem_write(`HCI_AW'(first + i), w, name);
    end
  endtask

  task automatic mem_check(input int first, input int count, input string name);
    logic [31:0] data;
    logic [1:0]  resp;
    for (int i = 0; i < count; i++) begin
      axi_read(word_addr(`HCI_AW'(first + i)), data, resp);
      check_resp(name, RESP_OKAY, resp);
      check_word($sformatf("%s word %0d", name, first + i), shadow[first + i], data);
    end
  endtask

  task automatic start_copy(input int src, input int dst, input int len, input string name);
    reg_write(IDX_SRC, 32'(src), name);
    reg_write(IDX_DST, 32'(dst), name);
    reg_write(IDX_LEN, 32'(len), name);
    reg_write(IDX_CTRL, 32'h1, name);
    // Expected image of the bank after the copy
    for (int i = 0; i < len; i++) begin
      shadow[(dst + i) % `BANK_DEPTH] = shadow[(src + i) % `BANK_DEPTH];
    end
  endtask

  task automatic wait_done(input string name);
    logic [31:0] data;
    logic [1:0]  resp;
    data = '0;
    while (!data[1]) begin
      axi_read(reg_addr(IDX_STATUS), data, resp);
      check_resp(name, RESP_OKAY, resp);
    end
  endtask

  task automatic test_regs();
    reg_check(IDX_STATUS, 32'h0, "regs status after reset");
    reg_write(IDX_SRC, 32'hdead_be3c, "regs write src");
    reg_write(IDX_DST, 32'h0000_01a5, "regs write dst");
    reg_write(IDX_LEN, 32'hffff_ff21, "regs write len");
    // Addresses keep 8 bits, the length 9 bits
    reg_check(IDX_SRC, 32'h0000_003c, "regs src");
    reg_check(IDX_DST, 32'h0000_00a5, "regs dst");
    reg_check(IDX_LEN, 32'h0000_0121, "regs len");
  endtask

  task automatic test_window();
    mem_fill(8'h40, 16, "window write");
    mem_check(8'h40, 16, "window read");
  endtask

  task automatic test_copy();
    mem_fill(8'h7f, 18, "copy guard fill");
    mem_fill(8'h00, 16, "copy src fill");
    start_copy(8'h00, 8'h80, 16, "copy start");
    wait_done("copy done");
    mem_check(8'h7f, 18, "copy dst");
    mem_check(8'h00, 16, "copy src");
  endtask

  task automatic test_zero_len();
    start_copy(8'h40, 8'h80, 0, "zero start");
    wait_done("zero done");
    mem_check(8'h7f, 18, "zero dst");
  endtask

  task automatic test_contention();
    mem_fill(8'ha0, 64, "contention src fill");
    start_copy(8'ha0, 8'h00, 64, "contention start");
    reg_check(IDX_STATUS, 32'h1, "contention busy");
    mem_check(8'h40, 16, "contention window");
    wait_done("contention done");
    mem_check(8'h00, 64, "contention dst");
    mem_check(8'ha0, 64, "contention src");
  endtask

  initial begin
    rst_ni  = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    lfsr_q  = 32'ha85e06be;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    test_regs();
    test_window();
    test_copy();
    test_zero_len();
    test_contention();

    if (dut0.u_chk.fail_cnt != 0) begin
      abort_run($sformatf("Protocol checker saw %0d assertion failures",
                          dut0.u_chk.fail_cnt));
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

//--- project.f
+incdir+rtl
rtl/hci_core_pkg.sv
rtl/copy_ctrl_pkg.sv
rtl/copy_regs.sv
rtl/copy_fsm.sv
rtl/beat_counter.sv
rtl/copy_streamer.sv
rtl/hci_core_mux_dynamic.sv
rtl/tcdm_bank.sv
rtl/copy_top.sv
verif/copy_chk.sv
verif/tb_copy.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the copy engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_copy -f project.f -Mdir obj_dir -o sim_copy
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_copy > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "TEST PASSED" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
